// ==== source/snd_pkg.sv ====
//********************************************************************
// Sound path package
// Sample widths, inter-stage frames, channel gains and the PCM pole
// coefficient shared by the filter, gain and mixer stages
//********************************************************************
package snd_pkg;

    localparam int SND_W    = 16;  // FM and mixed sample width
    localparam int PCM_W    = 9;   // ADPCM voice width
    localparam int SCALED_W = 18;  // Channel width after gain
    localparam int GAIN_W   = 8;   // 4.4 fixed point
    localparam int FRAC_BITS = 4;  // Fraction bits of gain and pole

    typedef logic signed [SND_W-1:0]    fm_sample_t;
    typedef logic signed [PCM_W-1:0]    pcm_sample_t;
    typedef logic signed [SCALED_W-1:0] scaled_t;
    typedef logic        [GAIN_W-1:0]   gain_t;

    // Output of the filter stage
    typedef struct packed {
        fm_sample_t  fm_left;
        fm_sample_t  fm_right;
        pcm_sample_t pcm;       // Low-pass filtered voice
    } filt_frame_t;

    // Output of the gain stage
    typedef struct packed {
        scaled_t ch_left;
        scaled_t ch_right;
        scaled_t ch_pcm;
    } scaled_frame_t;

    // One-pole low-pass, a = POLE_A/16, pole near 4 kHz
    localparam logic [FRAC_BITS-1:0] POLE_A = 4'd10;
    localparam logic [FRAC_BITS:0]   POLE_B = 5'd16 - {1'b0, POLE_A};  // 1 - a

    // Unity is 8'h10, so FM sits at half level
    localparam gain_t FM_GAIN = 8'h08;

    // Voice level selected by fxlevel
    localparam gain_t PCM_GAIN_TABLE [4] = '{8'h02, 8'h04, 8'h08, 8'h14};

    // Mono output limits
    localparam int SND_MAX = 32767;
    localparam int SND_MIN = -32768;

endpackage

// ==== source/pcm_pole_filter.sv ====
//********************************************************************
// PCM pole filter
// First stage of the sound path. Runs the ADPCM voice through a
// one-pole low-pass on each sample strobe and captures the FM pair
//********************************************************************
`timescale 1ns/1ps

module pcm_pole_filter import snd_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        sample,      // New FM and PCM values
    input  fm_sample_t  fm_left,
    input  fm_sample_t  fm_right,
    input  pcm_sample_t pcm_raw,
    output filt_frame_t filt,
    output logic        filt_valid
);

    pcm_sample_t pcm_state;
    pcm_sample_t pcm_next;
    fm_sample_t  fm_left_q;
    fm_sample_t  fm_right_q;

    // a*y[n-1] + (1-a)*x[n], both scaled by 16
    logic signed [PCM_W+4:0] acc;

    always_comb begin
        acc = pcm_state * $signed({1'b0, POLE_A})
            + pcm_raw * $signed(POLE_B);
        // Floor shift, result stays between old state and input
        pcm_next = acc[FRAC_BITS +: PCM_W];
    end

    // Filter state and strobe
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pcm_state  <= '0;
            filt_valid <= 1'b0;
        end else begin
            filt_valid <= sample;
            if (sample) begin
                pcm_state <= pcm_next;
            end
        end
    end

    // FM pair is payload only
    always_ff @(posedge clk) begin
        if (sample) begin
            fm_left_q  <= fm_left;
            fm_right_q <= fm_right;
        end
    end

    assign filt = '{
        fm_left:  fm_left_q,
        fm_right: fm_right_q,
        pcm:      pcm_state
    };

    // Filter output is one cycle behind the strobe
    a_filt_valid_after_sample: assert property (
        @(posedge clk) disable iff (rst)
        filt_valid |-> $past(sample)
    ) else $error("filt_valid without a sample strobe one cycle earlier");

endmodule

// ==== source/chan_gain.sv ====
//********************************************************************
// Channel gain stage
// Picks the FM and PCM gains from the user options and scales the
// three channels by their 4.4 fixed point gain
//********************************************************************
`timescale 1ns/1ps

module chan_gain import snd_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  filt_frame_t   filt,
    input  logic          filt_valid,
    input  logic [1:0]    fxlevel,     // Voice level option
    input  logic          enable_fm,
    input  logic          enable_psg,  // Voice channel enable
    output scaled_frame_t scaled,
    output logic          scaled_valid
);

    gain_t fm_gain;
    gain_t pcm_gain;

    // value * gain / 16, floor
    function automatic scaled_t scale(input fm_sample_t value, input gain_t gain);
        logic signed [SND_W+GAIN_W:0] prod;
        prod = value * $signed({1'b0, gain});
        return prod[FRAC_BITS +: SCALED_W];
    endfunction

    // Gains follow the options every cycle
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            fm_gain  <= '0;
            pcm_gain <= '0;
        end else begin
            fm_gain  <= enable_fm ? FM_GAIN : '0;
            pcm_gain <= enable_psg ? PCM_GAIN_TABLE[fxlevel] : '0;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            scaled_valid <= 1'b0;
        end else begin
            scaled_valid <= filt_valid;
        end
    end

    // Scaled frame held until the next strobe
    always_ff @(posedge clk) begin
        if (filt_valid) begin
            scaled.ch_left  <= scale(filt.fm_left, fm_gain);
            scaled.ch_right <= scale(filt.fm_right, fm_gain);
            scaled.ch_pcm   <= scale(fm_sample_t'(filt.pcm), pcm_gain);  // Sign extended
        end
    end

    // One output strobe per filter strobe, one cycle later
    a_scaled_follows_filt: assert property (
        @(posedge clk) disable iff (rst)
        scaled_valid == $past(filt_valid)
    ) else $error("scaled_valid does not follow filt_valid by one cycle");

endmodule

// ==== source/snd_mixer.sv ====
//********************************************************************
// Sound mixer
// Sums the three scaled channels into one mono sample, clamps it to
// the signed 16-bit range and flags a clamped sample as a peak
//********************************************************************
`timescale 1ns/1ps

module snd_mixer import snd_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  scaled_frame_t scaled,
    input  logic          scaled_valid,
    output fm_sample_t    snd,          // Mono output
    output logic          snd_valid,
    output logic          peak          // Last sample was clamped
);

    // Two extra bits hold the sum of three channels
    logic signed [SCALED_W+1:0] sum;
    fm_sample_t                 sat;
    logic                       clip;

    always_comb begin
        sum = scaled.ch_left + scaled.ch_right + scaled.ch_pcm;
        if (sum > SND_MAX) begin
            sat  = fm_sample_t'(SND_MAX);
            clip = 1'b1;
        end else if (sum < SND_MIN) begin
            sat  = fm_sample_t'(SND_MIN);
            clip = 1'b1;
        end else begin
            sat  = sum[SND_W-1:0];
            clip = 1'b0;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            snd       <= '0;
            peak      <= 1'b0;
            snd_valid <= 1'b0;
        end else begin
            snd_valid <= scaled_valid;
            if (scaled_valid) begin
                snd  <= sat;
                peak <= clip;
            end
        end
    end

    // Output known whenever it is presented
    a_snd_known: assert property (
        @(posedge clk) disable iff (rst)
        snd_valid |-> !$isunknown({snd, peak})
    ) else $error("snd or peak unknown while snd_valid is high");

endmodule

// ==== source/snd_path_top.sv ====
//********************************************************************
// Sound path top level
// Filter, gain and mixer stages in a three-cycle pipeline from the
// FM and PCM samples to the mono output
//********************************************************************
`timescale 1ns/1ps

module snd_path_top import snd_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        sample,      // FM sample strobe
    input  fm_sample_t  fm_left,
    input  fm_sample_t  fm_right,
    input  pcm_sample_t pcm_raw,
    // User options
    input  logic [1:0]  fxlevel,
    input  logic        enable_fm,
    input  logic        enable_psg,
    // Mono output
    output fm_sample_t  snd,
    output logic        snd_valid,
    output logic        peak
);

    filt_frame_t   filt;
    logic          filt_valid;
    scaled_frame_t scaled;
    logic          scaled_valid;

    pcm_pole_filter u_filter (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .sample     ( sample     ),
        .fm_left    ( fm_left    ),
        .fm_right   ( fm_right   ),
        .pcm_raw    ( pcm_raw    ),
        .filt       ( filt       ),
        .filt_valid ( filt_valid )
    );

    chan_gain u_gain (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .filt         ( filt         ),
        .filt_valid   ( filt_valid   ),
        .fxlevel      ( fxlevel      ),
        .enable_fm    ( enable_fm    ),
        .enable_psg   ( enable_psg   ),
        .scaled       ( scaled       ),
        .scaled_valid ( scaled_valid )
    );

    snd_mixer u_mixer (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .scaled       ( scaled       ),
        .scaled_valid ( scaled_valid ),
        .snd          ( snd          ),
        .snd_valid    ( snd_valid    ),
        .peak         ( peak         )
    );

endmodule

// ==== test/snd_path_checker.sv ====
//********************************************************************
// Sound path checker
// Follows the DUT ports, predicts the mono output of every sample
// strobe and compares it three cycles later
//********************************************************************
`timescale 1ns/1ps

module snd_path_checker import snd_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        sample,
    input  fm_sample_t  fm_left,
    input  fm_sample_t  fm_right,
    input  pcm_sample_t pcm_raw,
    input  logic [1:0]  fxlevel,
    input  logic        enable_fm,
    input  logic        enable_psg,
    input  fm_sample_t  snd,
    input  logic        snd_valid,
    input  logic        peak,
    output int          errors,
    output int          checked,
    output int          pending     // Samples still in flight
);

    typedef struct packed {
        logic [15:0] value;
        logic        clip;
    } mix_out_t;

    typedef struct packed {
        int       due;   // Cycle of the expected snd_valid
        mix_out_t out;
    } expect_t;

    expect_t expect_q[$];
    int      cycle;
    int      filt_state;

    // y = (a*y + (16-a)*x) / 16, floor
    function automatic int filter_step(input int state, input int raw);
        return (int'(POLE_A) * state + (16 - int'(POLE_A)) * raw) >>> 4;
    endfunction

    // Gain each channel, sum and clamp to 16 bits
    function automatic mix_out_t predict(input int fl, input int fr, input int pcm,
                                         input logic [1:0] lvl, input logic fm_on,
                                         input logic psg_on);
        int       g_fm;
        int       g_pcm;
        int       sum;
        mix_out_t res;
        g_fm  = fm_on ? int'(FM_GAIN) : 0;
        g_pcm = psg_on ? int'(PCM_GAIN_TABLE[lvl]) : 0;
        sum   = ((fl * g_fm) >>> 4) + ((fr * g_fm) >>> 4) + ((pcm * g_pcm) >>> 4);
        if (sum > 32767) begin
            res.value = 16'h7fff;
            res.clip  = 1'b1;
        end else if (sum < -32768) begin
            res.value = 16'h8000;
            res.clip  = 1'b1;
        end else begin
            res.value = sum[15:0];
            res.clip  = 1'b0;
        end
        return res;
    endfunction

    // Inputs and outputs are both settled at the falling edge
    always @(negedge clk) begin
        expect_t e;
        if (rst) begin
            expect_q.delete();
            cycle      = 0;
            filt_state = 0;
        end else begin
            cycle = cycle + 1;
            if (snd_valid) begin
                if (expect_q.size() == 0 || expect_q[0].due != cycle) begin
                    $display("Unexpected snd_valid pulse at cycle %0d", cycle);
                    errors++;
                end else begin
                    e = expect_q.pop_front();
                    if (snd !== e.out.value) begin
                        $display("ERR snd: got 0x%h expected 0x%h", snd, e.out.value);
                        errors++;
                    end
                    if (peak !== e.out.clip) begin
                        $display("ERR peak: got 0x%h expected 0x%h", peak, e.out.clip);
                        errors++;
                    end
                    checked++;
                end
            end else if (expect_q.size() != 0 && expect_q[0].due == cycle) begin
                $display("Missing snd_valid pulse for a sample due at cycle %0d", cycle);
                errors++;
                void'(expect_q.pop_front());
            end
            if (sample) begin
                filt_state = filter_step(filt_state, int'(pcm_raw));
                e.due = cycle + 3;
                e.out = predict(int'(fm_left), int'(fm_right), filt_state,
                                fxlevel, enable_fm, enable_psg);
                expect_q.push_back(e);
            end
        end
        pending = expect_q.size();
    end

endmodule

// ==== test/snd_path_tb.sv ====
//********************************************************************
// Sound path testbench
// Drives reset, PCM steps, FM gain, saturation and random sample
// streams into the DUT and prints one result line per test
//********************************************************************
`timescale 1ns/1ps

module snd_path_tb import snd_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        sample;
    fm_sample_t  fm_left;
    fm_sample_t  fm_right;
    pcm_sample_t pcm_raw;
    logic [1:0]  fxlevel;
    logic        enable_fm;
    logic        enable_psg;
    fm_sample_t  snd;
    logic        snd_valid;
    logic        peak;

    int          chk_errors;
    int          chk_count;
    int          chk_pending;

    logic [31:0] rng;
    bit          hung;          // Some wait ran out
    int          tests_passed;
    int          tests_failed;
    int          test_errors;   // Direct checks of the current test
    int          base_errors;
    int          base_count;
    int          sent;

    snd_path_top dut0 (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .sample     ( sample     ),
        .fm_left    ( fm_left    ),
        .fm_right   ( fm_right   ),
        .pcm_raw    ( pcm_raw    ),
        .fxlevel    ( fxlevel    ),
        .enable_fm  ( enable_fm  ),
        .enable_psg ( enable_psg ),
        .snd        ( snd        ),
        .snd_valid  ( snd_valid  ),
        .peak       ( peak       )
    );

    snd_path_checker checker0 (
        .clk        ( clk         ),
        .rst        ( rst         ),
        .sample     ( sample      ),
        .fm_left    ( fm_left     ),
        .fm_right   ( fm_right    ),
        .pcm_raw    ( pcm_raw     ),
        .fxlevel    ( fxlevel     ),
        .enable_fm  ( enable_fm   ),
        .enable_psg ( enable_psg  ),
        .snd        ( snd         ),
        .snd_valid  ( snd_valid   ),
        .peak       ( peak        ),
        .errors     ( chk_errors  ),
        .checked    ( chk_count   ),
        .pending    ( chk_pending )
    );

    always #50 clk = ~clk;  // 100 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Inputs change just after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic set_options(input logic [1:0] lvl, input logic fm_on, input logic psg_on);
        fxlevel    = lvl;
        enable_fm  = fm_on;
        enable_psg = psg_on;
        tick();
    endtask

    task automatic strobe(input fm_sample_t fl, input fm_sample_t fr, input pcm_sample_t pcm);
        sample   = 1'b1;
        fm_left  = fl;
        fm_right = fr;
        pcm_raw  = pcm;
        sent++;
        tick();
        sample = 1'b0;
    endtask

    task automatic rand_strobe();
        fm_sample_t fl;
        fm_sample_t fr;
        rng = xorshift32(rng);
        fl  = rng[15:0];
        fr  = rng[31:16];
        rng = xorshift32(rng);
        strobe(fl, fr, rng[8:0]);
    endtask

    // Wait until every sample in flight has come out
    task automatic drain();
        int waited;
        waited = 0;
        while (chk_pending != 0 && waited < 20) begin
            tick();
            waited++;
        end
        if (chk_pending != 0) begin
            $display("Timeout waiting for %0d outstanding samples", chk_pending);
            hung = 1'b1;
        end
        tick();
    endtask

    task automatic expect_eq(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h expected 0x%h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic begin_test();
        base_errors = chk_errors;
        base_count  = chk_count;
        sent        = 0;
        test_errors = 0;
    endtask

    task automatic end_test(input int num, input string name);
        int errs;
        int outs;
        outs = chk_count - base_count;
        if (outs != sent) begin
            $display("Test %0d sent %0d samples but %0d outputs were checked", num, sent, outs);
            test_errors++;
        end
        errs = chk_errors - base_errors + test_errors;
        if (errs == 0 && !hung) begin
            $display("Test %0d %s: PASS", num, name);
            tests_passed++;
        end else begin
            $display("Test %0d %s: FAIL (%0d errors)", num, name, errs);
            tests_failed++;
        end
    endtask

    initial begin
        int lvl;
        int burst;
        int i;
        clk          = 1'b0;
        rst          = 1'b1;
        sample       = 1'b0;
        fm_left      = '0;
        fm_right     = '0;
        pcm_raw      = '0;
        fxlevel      = 2'd0;
        enable_fm    = 1'b0;
        enable_psg   = 1'b0;
        rng          = 32'd37;
        hung         = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        begin_test();
        repeat (3) begin
            expect_eq("snd", snd, 16'h0000);
            expect_eq("peak", {15'd0, peak}, 16'h0000);
            expect_eq("snd_valid", {15'd0, snd_valid}, 16'h0000);
            tick();
        end
        end_test(1, "reset state");

        // Step from zero for every voice level
        begin_test();
        for (lvl = 0; lvl < 4; lvl++) begin
            set_options(2'(lvl), 1'b0, 1'b1);
            repeat (6) strobe(16'sd0, 16'sd0, 9'sd0);
            repeat (10) begin
                strobe(16'sd0, 16'sd0, 9'sd200);
                tick();
            end
            drain();
        end
        set_options(2'd3, 1'b0, 1'b0);
        repeat (4) strobe(16'sd0, 16'sd0, 9'sd200);
        drain();
        expect_eq("snd", snd, 16'h0000);
        end_test(2, "PCM step response");

        begin_test();
        set_options(2'd1, 1'b1, 1'b1);
        repeat (10) rand_strobe();
        drain();
        set_options(2'd1, 1'b0, 1'b1);
        repeat (10) rand_strobe();
        drain();
        end_test(3, "FM gain and enable");

        begin_test();
        set_options(2'd3, 1'b1, 1'b1);
        repeat (6) strobe(16'sh7fff, 16'sh7fff, 9'sh0ff);
        drain();
        expect_eq("snd", snd, 16'h7fff);
        expect_eq("peak", {15'd0, peak}, 16'h0001);
        repeat (6) strobe(16'sh8000, 16'sh8000, 9'sh100);
        drain();
        expect_eq("snd", snd, 16'h8000);
        expect_eq("peak", {15'd0, peak}, 16'h0001);
        strobe(16'sd0, 16'sd0, 9'sd0);  // Quiet sample
        drain();
        expect_eq("peak", {15'd0, peak}, 16'h0000);
        end_test(4, "saturation and peak");

        begin_test();
        set_options(2'd2, 1'b1, 1'b1);
        repeat (24) rand_strobe();
        drain();
        end_test(5, "back-to-back strobes");

        begin_test();
        for (burst = 0; burst < 40; burst++) begin
            rng = xorshift32(rng);
            set_options(rng[1:0], rng[2], rng[3]);
            for (i = 0; i < 6; i++) begin
                rand_strobe();
                rng = xorshift32(rng);
                repeat (rng[1:0]) tick();  // Gap of 0 to 3 cycles
            end
            drain();
        end
        end_test(6, "random spacing and options");

        $display("%0d tests passed, %0d failed, %0d samples checked, %0d checker errors",
                 tests_passed, tests_failed, chk_count, chk_errors);
        if (tests_failed == 0 && chk_errors == 0 && !hung) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
source/snd_pkg.sv
source/pcm_pole_filter.sv
source/chan_gain.sv
source/snd_mixer.sv
source/snd_path_top.sv
test/snd_path_checker.sv
test/snd_path_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the sound path testbench with Verilator and runs it.
# The run counts as failed when sim.log holds the fail message.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module snd_path_tb \
    > build.log 2>&1 &&
./obj_dir/Vsnd_path_tb > sim.log 2>&1 ||
{ cat build.log; echo "Simulation failed" >> sim.log; }

cat sim.log

grep -q "Simulation failed" sim.log && exit 1 || exit 0
